/* rvc_config.svh */
// Build-time sizes shared by the RVC decode stage
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// ##########################################################################
// Datapath
// ##########################################################################

// Width of data, immediates and program counters
`define XLEN 64

// ##########################################################################
// Flow control
// ##########################################################################

// Fetch buffer entries, which is also the credit count fetch starts with
`define FETCH_BUF_DEPTH 4

// Credits the issue queue hands out after reset
`define ISSUE_CREDITS 4

`endif

/* rvc_pkg.sv */
// Types shared by the RVC decode stage: opcodes, FSM states, fetch packet and micro-op
`include "rvc_config.svh"

package rvc_pkg;

	// ##########################################################################
	// Enumerations
	// ##########################################################################

	// Micro-op opcodes produced by the expander
	typedef enum logic [4:0] {
		OP_ADDI,
		OP_ADDIW,
		OP_LUI,
		OP_ANDI,
		OP_SLLI,
		OP_SRLI,
		OP_SRAI,
		OP_ADD,
		OP_ADDW,
		OP_SUB,
		OP_SUBW,
		OP_XOR,
		OP_OR,
		OP_AND,
		OP_LW,
		OP_LD,
		OP_SW,
		OP_SD,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_JALR,
		OP_EBREAK,
		OP_ILLEGAL
	} uop_op_t;

	// Half selection states
	typedef enum logic [1:0] {
		ST_IDLE,  // Waiting for a head packet
		ST_LOW,   // Low half of the head packet goes next
		ST_HIGH   // High half of the head packet goes next
	} half_state_t;

	// ##########################################################################
	// Records
	// ##########################################################################

	// One fetch word as delivered by fetch
	// Bit 1 of pc set means only the high half carries an instruction
	typedef struct packed {
		logic [`XLEN-1:0] pc;    // Address of the first valid halfword
		logic [31:0]      word;
	} fetch_pkt_t;

	// Decoded micro-op handed to the issue stage
	typedef struct packed {
		uop_op_t          op;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] imm;
		logic [5:0]       shamt;
		logic [4:0]       rd;
		logic [4:0]       rs1;
		logic [4:0]       rs2;
	} uop_t;

endpackage

/* rvc_expander.sv */
// Combinational expansion of one RVC halfword into a decoded micro-op
`timescale 1ns/1ps
`include "rvc_config.svh"

module rvc_expander (
	input  logic [15:0]      half,
	input  logic [`XLEN-1:0] pc,
	output rvc_pkg::uop_t    uop
);
	import rvc_pkg::*;

	localparam int XL = `XLEN;

	logic [1:0]    quad;
	logic [2:0]    funct3;
	logic [4:0]    rd_full;   // Full register field in bits 11:7
	logic [4:0]    rs2_full;  // Full register field in bits 6:2
	logic [4:0]    rd_cmp;    // Compressed register in bits 4:2, maps to x8..x15
	logic [4:0]    rs1_cmp;   // Compressed register in bits 9:7
	logic [5:0]    shamt_f;
	logic [XL-1:0] imm_ci;
	logic [XL-1:0] imm_lui;
	logic [XL-1:0] imm_16sp;
	logic [XL-1:0] imm_4spn;
	logic [XL-1:0] imm_lw;
	logic [XL-1:0] imm_ld;
	logic [XL-1:0] imm_j;
	logic [XL-1:0] imm_b;
	logic [XL-1:0] imm_lwsp;
	logic [XL-1:0] imm_ldsp;
	logic [XL-1:0] imm_swsp;
	logic [XL-1:0] imm_sdsp;

	assign quad     = half[1:0];
	assign funct3   = half[15:13];
	assign rd_full  = half[11:7];
	assign rs2_full = half[6:2];
	assign rd_cmp   = {2'b01, half[4:2]};
	assign rs1_cmp  = {2'b01, half[9:7]};
	assign shamt_f  = {half[12], half[6:2]};

	// ##########################################################################
	// Immediate formats
	// ##########################################################################

	assign imm_ci   = {{(XL-6){half[12]}}, half[12], half[6:2]};
	assign imm_lui  = {{(XL-18){half[12]}}, half[12], half[6:2], 12'b0};
	assign imm_16sp = {{(XL-10){half[12]}}, half[12], half[4:3], half[5], half[2], half[6], 4'b0};
	assign imm_4spn = {{(XL-10){1'b0}}, half[10:7], half[12:11], half[5], half[6], 2'b0};
	assign imm_lw   = {{(XL-7){1'b0}}, half[5], half[12:10], half[6], 2'b0};
	assign imm_ld   = {{(XL-8){1'b0}}, half[6:5], half[12:10], 3'b0};
	assign imm_j    = {{(XL-12){half[12]}}, half[12], half[8], half[10:9], half[6], half[7],
		half[2], half[11], half[5:3], 1'b0};
	assign imm_b    = {{(XL-9){half[12]}}, half[12], half[6:5], half[2], half[11:10],
		half[4:3], 1'b0};
	assign imm_lwsp = {{(XL-8){1'b0}}, half[3:2], half[12], half[6:4], 2'b0};
	assign imm_ldsp = {{(XL-9){1'b0}}, half[4:2], half[12], half[6:5], 3'b0};
	assign imm_swsp = {{(XL-8){1'b0}}, half[8:7], half[12:9], 2'b0};
	assign imm_sdsp = {{(XL-9){1'b0}}, half[9:7], half[12:10], 3'b0};

	// ##########################################################################
	// Opcode and operand selection
	// ##########################################################################

	always_comb begin
		uop    = '0;  // Anything not matched below stays an illegal op with zero fields
		uop.op = OP_ILLEGAL;
		uop.pc = pc;
		case (quad)
			2'b00: begin
				case (funct3)
					3'b000: if (imm_4spn != '0) begin  // C.ADDI4SPN
						uop.op = OP_ADDI; uop.rd = rd_cmp; uop.rs1 = 5'd2; uop.imm = imm_4spn;
					end
					3'b010: begin
						uop.op = OP_LW; uop.rd = rd_cmp; uop.rs1 = rs1_cmp; uop.imm = imm_lw;
					end
					3'b011: begin
						uop.op = OP_LD; uop.rd = rd_cmp; uop.rs1 = rs1_cmp; uop.imm = imm_ld;
					end
					3'b110: begin
						uop.op = OP_SW; uop.rs1 = rs1_cmp; uop.rs2 = rd_cmp; uop.imm = imm_lw;
					end
					3'b111: begin
						uop.op = OP_SD; uop.rs1 = rs1_cmp; uop.rs2 = rd_cmp; uop.imm = imm_ld;
					end
					default: ;
				endcase
			end
			2'b01: begin
				case (funct3)
					3'b000: if (rd_full != '0) begin  // C.ADDI
						uop.op = OP_ADDI; uop.rd = rd_full; uop.rs1 = rd_full; uop.imm = imm_ci;
					end else if (half[12:2] == '0) begin
						uop.op = OP_ADDI;  // C.NOP is addi x0, x0, 0
					end
					3'b001: if (rd_full != '0) begin
						uop.op = OP_ADDIW; uop.rd = rd_full; uop.rs1 = rd_full; uop.imm = imm_ci;
					end
					3'b010: if (rd_full != '0) begin  // C.LI adds to x0
						uop.op = OP_ADDI; uop.rd = rd_full; uop.imm = imm_ci;
					end
					3'b011: if (rd_full == 5'd2) begin  // C.ADDI16SP
						uop.op = OP_ADDI; uop.rd = 5'd2; uop.rs1 = 5'd2; uop.imm = imm_16sp;
					end else if (rd_full != '0) begin
						uop.op = OP_LUI; uop.rd = rd_full; uop.imm = imm_lui;
					end
					3'b100: begin
						case (half[11:10])
							2'b00: if (shamt_f != '0) begin
								uop.op = OP_SRLI; uop.rd = rs1_cmp; uop.rs1 = rs1_cmp; uop.shamt = shamt_f;
							end
							2'b01: if (shamt_f != '0) begin
								uop.op = OP_SRAI; uop.rd = rs1_cmp; uop.rs1 = rs1_cmp; uop.shamt = shamt_f;
							end
							2'b10: begin
								uop.op = OP_ANDI; uop.rd = rs1_cmp; uop.rs1 = rs1_cmp; uop.imm = imm_ci;
							end
							default: if (!(half[12] && half[6])) begin  // Register-register group
								uop.rd  = rs1_cmp;
								uop.rs1 = rs1_cmp;
								uop.rs2 = rd_cmp;
								case ({half[12], half[6:5]})
									3'b000:  uop.op = OP_SUB;
									3'b001:  uop.op = OP_XOR;
									3'b010:  uop.op = OP_OR;
									3'b011:  uop.op = OP_AND;
									3'b100:  uop.op = OP_SUBW;
									default: uop.op = OP_ADDW;
								endcase
							end
						endcase
					end
					3'b101: begin
						uop.op = OP_JAL; uop.imm = imm_j;  // C.J links into x0
					end
					3'b110: begin
						uop.op = OP_BEQ; uop.rs1 = rs1_cmp; uop.imm = imm_b;
					end
					default: begin
						uop.op = OP_BNE; uop.rs1 = rs1_cmp; uop.imm = imm_b;
					end
				endcase
			end
			2'b10: begin
				case (funct3)
					3'b000: if (rd_full != '0 && shamt_f != '0) begin
						uop.op = OP_SLLI; uop.rd = rd_full; uop.rs1 = rd_full; uop.shamt = shamt_f;
					end
					3'b010: if (rd_full != '0) begin
						uop.op = OP_LW; uop.rd = rd_full; uop.rs1 = 5'd2; uop.imm = imm_lwsp;
					end
					3'b011: if (rd_full != '0) begin
						uop.op = OP_LD; uop.rd = rd_full; uop.rs1 = 5'd2; uop.imm = imm_ldsp;
					end
					3'b100: if (!half[12]) begin
						if (rs2_full != '0) begin  // C.MV adds to x0
							uop.op = OP_ADD; uop.rd = rd_full; uop.rs2 = rs2_full;
						end else if (rd_full != '0) begin  // C.JR
							uop.op = OP_JALR; uop.rs1 = rd_full;
						end
					end else if (rs2_full != '0) begin
						if (rd_full != '0) begin
							uop.op = OP_ADD; uop.rd = rd_full; uop.rs1 = rd_full; uop.rs2 = rs2_full;
						end
					end else if (rd_full != '0) begin  // C.JALR links into ra
						uop.op = OP_JALR; uop.rd = 5'd1; uop.rs1 = rd_full;
					end else begin
						uop.op = OP_EBREAK;
					end
					3'b110: begin
						uop.op = OP_SW; uop.rs1 = 5'd2; uop.rs2 = rs2_full; uop.imm = imm_swsp;
					end
					3'b111: begin
						uop.op = OP_SD; uop.rs1 = 5'd2; uop.rs2 = rs2_full; uop.imm = imm_sdsp;
					end
					default: ;
				endcase
			end
			default: ;  // Low bits 11 belong to 32-bit instructions
		endcase
	end

endmodule

/* fetch_buffer.sv */
// Fetch packet FIFO that hands one credit back to fetch per released packet
`timescale 1ns/1ps
`include "rvc_config.svh"

module fetch_buffer (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                fetch_valid,
	input  rvc_pkg::fetch_pkt_t fetch_pkt,
	input  logic                pop,
	output logic                head_valid,
	output rvc_pkg::fetch_pkt_t head_pkt,
	output logic                fetch_credit
);
	import rvc_pkg::*;

	localparam int DEPTH = `FETCH_BUF_DEPTH;
	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW    = $clog2(DEPTH + 1);

	fetch_pkt_t    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// Circular pointer advance
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + AW'(1);
	endfunction

	assign head_valid = (count != '0);
	assign head_pkt   = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			fetch_credit <= 1'b0;
		end else begin
			if (fetch_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({fetch_valid, pop})
				2'b10:   count <= count + CW'(1);
				2'b01:   count <= count - CW'(1);
				default: ;  // Push and pop together keep the fill level
			endcase
			fetch_credit <= pop;  // The entry is free again, so fetch may refill it
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid)
			mem[wr_ptr] <= fetch_pkt;
	end

endmodule

/* issue_credit_counter.sv */
// Count of credits granted by the downstream issue queue
`timescale 1ns/1ps
`include "rvc_config.svh"

module issue_credit_counter (
	input  logic clk,
	input  logic arst_n,
	input  logic send,
	input  logic uop_credit,
	output logic credit_avail
);

	localparam int CNT_W = $clog2(`ISSUE_CREDITS + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= CNT_W'(`ISSUE_CREDITS);  // Issue queue starts out empty
		end else begin
			if (send && !uop_credit)
				count <= count - CNT_W'(1);
			else if (uop_credit && !send)
				count <= count + CNT_W'(1);
		end
	end

	assign credit_avail = (count != '0);

endmodule

/* half_select_fsm.sv */
// FSM that steps through the halves of the head packet and registers each micro-op
`timescale 1ns/1ps
`include "rvc_config.svh"

module half_select_fsm (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                head_valid,
	input  rvc_pkg::fetch_pkt_t head_pkt,
	input  logic                credit_avail,
	input  rvc_pkg::uop_t       exp_uop,
	output logic [15:0]         half,
	output logic [`XLEN-1:0]    half_pc,
	output logic                pop,
	output logic                send,
	output logic                uop_valid,
	output rvc_pkg::uop_t       uop
);
	import rvc_pkg::*;

	half_state_t state;
	half_state_t state_nxt;

	// Halfword steering toward the expander
	assign half    = (state == ST_HIGH) ? head_pkt.word[31:16] : head_pkt.word[15:0];
	assign half_pc = (state == ST_HIGH && !head_pkt.pc[1]) ? head_pkt.pc + `XLEN'd2
		: head_pkt.pc;

	always_comb begin
		state_nxt = state;
		send      = 1'b0;
		pop       = 1'b0;
		case (state)
			ST_IDLE: begin
				if (head_valid)
					state_nxt = head_pkt.pc[1] ? ST_HIGH : ST_LOW;  // Skip an invalid low half
			end
			ST_LOW: begin
				if (head_valid && credit_avail) begin
					send      = 1'b1;
					state_nxt = ST_HIGH;
				end
			end
			ST_HIGH: begin
				if (head_valid && credit_avail) begin  // Last half, so release the packet
					send      = 1'b1;
					pop       = 1'b1;
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			uop_valid <= 1'b0;
		end else begin
			state     <= state_nxt;
			uop_valid <= send;  // Stays low while credits are exhausted
		end
	end

	// Micro-op payload is captured with each emitted halfword
	always_ff @(posedge clk) begin
		if (send)
			uop <= exp_uop;
	end

endmodule

/* rvc_decode_top.sv */
// RVC decode stage linking fetch buffer, half select FSM, credit counter and expander
`timescale 1ns/1ps
`include "rvc_config.svh"

module rvc_decode_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                fetch_valid,
	input  rvc_pkg::fetch_pkt_t fetch_pkt,
	output logic                fetch_credit,
	output logic                uop_valid,
	output rvc_pkg::uop_t       uop,
	input  logic                uop_credit
);
	import rvc_pkg::*;

	logic             head_valid;
	fetch_pkt_t       head_pkt;
	logic             pop;
	logic             send;
	logic             credit_avail;
	logic [15:0]      half;
	logic [`XLEN-1:0] half_pc;
	uop_t             exp_uop;

	// ##########################################################################
	// Fetch side
	// ##########################################################################

	fetch_buffer fetch_buffer_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_valid  (fetch_valid),
		.fetch_pkt    (fetch_pkt),
		.pop          (pop),
		.head_valid   (head_valid),
		.head_pkt     (head_pkt),
		.fetch_credit (fetch_credit)
	);

	// ##########################################################################
	// Decode and issue side
	// ##########################################################################

	half_select_fsm half_select_fsm_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.head_valid   (head_valid),
		.head_pkt     (head_pkt),
		.credit_avail (credit_avail),
		.exp_uop      (exp_uop),
		.half         (half),
		.half_pc      (half_pc),
		.pop          (pop),
		.send         (send),
		.uop_valid    (uop_valid),
		.uop          (uop)
	);

	rvc_expander rvc_expander_i (
		.half (half),
		.pc   (half_pc),
		.uop  (exp_uop)
	);

	issue_credit_counter issue_credit_counter_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.send         (send),
		.uop_credit   (uop_credit),
		.credit_avail (credit_avail)
	);

endmodule

/* rvc_decode_properties.sv */
// Concurrent assertions on the RVC decode stage flow control and outputs
`timescale 1ns/1ps
`include "rvc_config.svh"

module rvc_decode_properties (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             fetch_valid,
	input  logic             pop,
	input  logic             uop_valid,
	input  logic             uop_credit,
	input  logic             fetch_credit,
	input  rvc_pkg::uop_op_t uop_op
);
	import rvc_pkg::*;

	localparam int DEPTH = `FETCH_BUF_DEPTH;

	int   occupancy;  // Shadow fill level of the fetch buffer
	int   issue_cnt;  // Shadow of the issue credit count, as it stood at the launch edge
	logic credit_d;   // A returned credit counts from the edge after its pulse

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			occupancy <= 0;
		else
			occupancy <= occupancy + (fetch_valid ? 1 : 0) - (pop ? 1 : 0);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issue_cnt <= `ISSUE_CREDITS;
			credit_d  <= 1'b0;
		end else begin
			issue_cnt <= issue_cnt - (uop_valid ? 1 : 0) + (credit_d ? 1 : 0);
			credit_d  <= uop_credit;
		end
	end

	// A micro-op appears only against a credit the issue side still owed
	assert property (@(posedge clk) disable iff (!arst_n) uop_valid |-> issue_cnt > 0)
		else $error("micro-op issued with the credit count at zero");

	assert property (@(posedge clk) disable iff (!arst_n) fetch_valid |-> occupancy < DEPTH)
		else $error("fetch packet written into a full buffer");

	assert property (@(posedge clk) $rose(arst_n) |-> !uop_valid && !fetch_credit)
		else $error("output activity in the first cycle after reset");

	assert property (@(posedge clk) disable iff (!arst_n) uop_valid |-> !$isunknown(uop_op))
		else $error("micro-op opcode unknown while valid");

endmodule

bind rvc_decode_top rvc_decode_properties rvc_decode_properties_i (
	.clk          (clk),
	.arst_n       (arst_n),
	.fetch_valid  (fetch_valid),
	.pop          (pop),
	.uop_valid    (uop_valid),
	.uop_credit   (uop_credit),
	.fetch_credit (fetch_credit),
	.uop_op       (uop.op)
);

/* rvc_decode_tb.sv */
// Testbench for the RVC decode stage with fetch and issue credit models and a scoreboard
`timescale 1ns/1ps
`include "rvc_config.svh"

module rvc_decode_tb;
	import rvc_pkg::*;

	localparam int N_FORMS    = 33;
	localparam int N_RANDOM   = 300;
	localparam int MAX_HALVES = 3 * N_FORMS + 4 + 6 + 2 * N_RANDOM;

	logic       clk;
	logic       arst_n;
	logic       fetch_valid;
	fetch_pkt_t fetch_pkt;
	logic       fetch_credit;
	logic       uop_valid;
	uop_t       uop;
	logic       uop_credit;

	uop_t        exp_q[$];      // Scoreboard of expected micro-ops
	int          pending[$];    // Cycles at which issue credits go back
	int          cycle;
	int          fetch_credits;
	int          credits_returned;
	int          pkts_sent;
	int          uops_seen;
	logic        hold_credits;
	string       cur_test;
	logic [63:0] pc;
	int          mark;

	// One of each supported RVC form
	logic [15:0] forms [N_FORMS] = '{
		16'h154C, 16'h4B58, 16'h6F70, 16'hC2A4, 16'hE6DC, 16'h0001, 16'h0505, 16'h357D,
		16'h5541, 16'h7141, 16'h6285, 16'h8185, 16'h9595, 16'h9A7D, 16'h8C09, 16'h8C2D,
		16'h8C4D, 16'h8C6D, 16'h9C0D, 16'h9C2D, 16'hB7F5, 16'hC381, 16'hF0FD, 16'h0586,
		16'h4592, 16'h6622, 16'h8082, 16'h852E, 16'h9002, 16'h9582, 16'h95AE, 16'hC42E,
		16'hE82A
	};
	logic [15:0] illegal_forms [4] = '{16'h1233, 16'h8000, 16'h0000, 16'h2000};

	rvc_decode_top rvc_decode_top_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_valid  (fetch_valid),
		.fetch_pkt    (fetch_pkt),
		.fetch_credit (fetch_credit),
		.uop_valid    (uop_valid),
		.uop          (uop),
		.uop_credit   (uop_credit)
	);

	// ##########################################################################
	// Reference model
	// ##########################################################################

	function automatic logic [63:0] sext(input logic [63:0] v, input int msb);
		logic [63:0] r;
		r = v;
		for (int i = msb + 1; i < 64; i++)
			r[i] = v[msb];
		return r;
	endfunction

	function automatic uop_t rvc_expand_ref(input logic [15:0] h, input logic [63:0] hpc);
		uop_t        u;
		logic [63:0] im;
		logic [4:0]  r_hi;
		logic [4:0]  r_lo;
		logic [4:0]  c_a;
		logic [4:0]  c_b;
		logic [5:0]  sh;
		u    = '0;
		im   = '0;
		u.op = OP_ILLEGAL;
		r_hi = h[11:7];
		r_lo = h[6:2];
		c_a  = 5'd8 + {2'b00, h[9:7]};  // Compressed registers map to x8..x15
		c_b  = 5'd8 + {2'b00, h[4:2]};
		sh   = {h[12], h[6:2]};
		case ({h[1:0], h[15:13]})
			5'b00_000: begin
				im[5:4] = h[12:11];
				im[9:6] = h[10:7];
				im[2]   = h[6];
				im[3]   = h[5];
				if (im != '0) begin
					u.op  = OP_ADDI;
					u.rd  = c_b;
					u.rs1 = 5'd2;
				end
			end
			5'b00_010, 5'b00_110: begin
				im[5:3] = h[12:10];
				im[2]   = h[6];
				im[6]   = h[5];
				u.op    = h[15] ? OP_SW : OP_LW;
				u.rs1   = c_a;
				if (h[15])
					u.rs2 = c_b;
				else
					u.rd = c_b;
			end
			5'b00_011, 5'b00_111: begin
				im[5:3] = h[12:10];
				im[7:6] = h[6:5];
				u.op    = h[15] ? OP_SD : OP_LD;
				u.rs1   = c_a;
				if (h[15])
					u.rs2 = c_b;
				else
					u.rd = c_b;
			end
			5'b01_000: begin
				im = sext({58'b0, sh}, 5);
				if (r_hi != '0) begin
					u.op  = OP_ADDI;
					u.rd  = r_hi;
					u.rs1 = r_hi;
				end else if (h[12:2] == '0) begin
					u.op = OP_ADDI;  // NOP
				end
			end
			5'b01_001: begin
				im = sext({58'b0, sh}, 5);
				if (r_hi != '0) begin
					u.op  = OP_ADDIW;
					u.rd  = r_hi;
					u.rs1 = r_hi;
				end
			end
			5'b01_010: begin
				im = sext({58'b0, sh}, 5);
				if (r_hi != '0) begin
					u.op = OP_ADDI;
					u.rd = r_hi;
				end
			end
			5'b01_011: begin
				if (r_hi == 5'd2) begin
					im[9]   = h[12];
					im[4]   = h[6];
					im[6]   = h[5];
					im[8:7] = h[4:3];
					im[5]   = h[2];
					im      = sext(im, 9);
					u.op    = OP_ADDI;
					u.rd    = 5'd2;
					u.rs1   = 5'd2;
				end else if (r_hi != '0) begin
					im[17]    = h[12];
					im[16:12] = h[6:2];
					im        = sext(im, 17);
					u.op      = OP_LUI;
					u.rd      = r_hi;
				end
			end
			5'b01_100: begin
				u.rd  = c_a;
				u.rs1 = c_a;
				case (h[11:10])
					2'b00: if (sh != '0) begin
						u.op    = OP_SRLI;
						u.shamt = sh;
					end
					2'b01: if (sh != '0) begin
						u.op    = OP_SRAI;
						u.shamt = sh;
					end
					2'b10: begin
						u.op = OP_ANDI;
						im   = sext({58'b0, sh}, 5);
					end
					default: begin
						u.rs2 = c_b;
						case ({h[12], h[6:5]})
							3'b000: u.op = OP_SUB;
							3'b001: u.op = OP_XOR;
							3'b010: u.op = OP_OR;
							3'b011: u.op = OP_AND;
							3'b100: u.op = OP_SUBW;
							3'b101: u.op = OP_ADDW;
							default: u.op = OP_ILLEGAL;
						endcase
					end
				endcase
			end
			5'b01_101: begin
				im[11]  = h[12];
				im[4]   = h[11];
				im[9:8] = h[10:9];
				im[10]  = h[8];
				im[6]   = h[7];
				im[7]   = h[6];
				im[3:1] = h[5:3];
				im[5]   = h[2];
				im      = sext(im, 11);
				u.op    = OP_JAL;  // C.J links into x0
			end
			5'b01_110, 5'b01_111: begin
				im[8]   = h[12];
				im[4:3] = h[11:10];
				im[7:6] = h[6:5];
				im[2:1] = h[4:3];
				im[5]   = h[2];
				im      = sext(im, 8);
				u.op    = h[13] ? OP_BNE : OP_BEQ;
				u.rs1   = c_a;
			end
			5'b10_000: if (r_hi != '0 && sh != '0) begin
				u.op    = OP_SLLI;
				u.rd    = r_hi;
				u.rs1   = r_hi;
				u.shamt = sh;
			end
			5'b10_010: begin
				im[5]   = h[12];
				im[4:2] = h[6:4];
				im[7:6] = h[3:2];
				if (r_hi != '0) begin
					u.op  = OP_LW;
					u.rd  = r_hi;
					u.rs1 = 5'd2;
				end
			end
			5'b10_011: begin
				im[5]   = h[12];
				im[4:3] = h[6:5];
				im[8:6] = h[4:2];
				if (r_hi != '0) begin
					u.op  = OP_LD;
					u.rd  = r_hi;
					u.rs1 = 5'd2;
				end
			end
			5'b10_100: begin
				if (r_lo != '0) begin
					if (!h[12] || r_hi != '0) begin  // MV or ADD
						u.op  = OP_ADD;
						u.rd  = r_hi;
						u.rs2 = r_lo;
						if (h[12])
							u.rs1 = r_hi;
					end
				end else if (r_hi != '0) begin
					u.op  = OP_JALR;
					u.rs1 = r_hi;
					if (h[12])
						u.rd = 5'd1;
				end else if (h[12]) begin
					u.op = OP_EBREAK;
				end
			end
			5'b10_110: begin
				im[5:2] = h[12:9];
				im[7:6] = h[8:7];
				u.op    = OP_SW;
				u.rs1   = 5'd2;
				u.rs2   = r_lo;
			end
			5'b10_111: begin
				im[5:3] = h[12:10];
				im[8:6] = h[9:7];
				u.op    = OP_SD;
				u.rs1   = 5'd2;
				u.rs2   = r_lo;
			end
			default: ;
		endcase
		u.imm = im;
		if (u.op == OP_ILLEGAL) begin
			u    = '0;
			u.op = OP_ILLEGAL;  // Unmatched patterns carry no operands
		end
		u.pc = hpc;
		return u;
	endfunction

	// ##########################################################################
	// Checks and helpers
	// ##########################################################################

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_uop(input string test, input uop_t exp, input uop_t act);
		if (exp !== act)
			fail_now($sformatf("[ERROR] %s: expected %s %h, actual %s %h", test,
				exp.op.name(), exp, act.op.name(), act));
	endtask

	task automatic check_credit_count(input string test, input int exp, input int act);
		if (exp != act)
			fail_now($sformatf("[ERROR] %s: expected %0d, actual %0d", test, exp, act));
	endtask

	function automatic logic [15:0] random_half();
		logic [15:0] h;
		uop_t        u;
		do begin
			h = 16'($urandom);
			if (h[1:0] == 2'b11)
				h[1:0] = 2'($urandom_range(0, 2));
			u = rvc_expand_ref(h, '0);
		end while (u.op == OP_ILLEGAL);
		return h;
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Fetch model waits for a credit and then drives one packet for one cycle
	task automatic send_pkt(input logic [63:0] ppc, input logic [31:0] word);
		while (fetch_credits == 0)
			idle(1);
		fetch_valid    = 1'b1;
		fetch_pkt.pc   = ppc;
		fetch_pkt.word = word;
		fetch_credits--;
		pkts_sent++;
		if (!ppc[1])
			exp_q.push_back(rvc_expand_ref(word[15:0], ppc));
		exp_q.push_back(rvc_expand_ref(word[31:16], ppc[1] ? ppc : ppc + 64'd2));
		idle(1);
		fetch_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || pending.size() != 0)
			idle(1);
		idle(2);  // Let the last credit reach the counter
	endtask

	// ##########################################################################
	// Clock, models and scoreboard
	// ##########################################################################

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Fetch credits handed back by the stage
	always @(posedge clk) begin
		if (fetch_credit) begin
			fetch_credits++;
			credits_returned++;
		end
	end

	// Compare process, which also keeps the cycle count for the issue model
	always @(posedge clk) begin
		cycle++;
		if (arst_n && uop_valid) begin
			uops_seen++;
			pending.push_back(cycle + int'($urandom_range(0, 6)));
			if (exp_q.size() == 0)
				fail_now($sformatf("%s: a micro-op arrived that was never expected", cur_test));
			else
				check_uop(cur_test, exp_q.pop_front(), uop);
		end
	end

	// Issue model returns one credit per cycle once its delay has run out
	initial begin
		uop_credit = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			uop_credit = 1'b0;
			if (arst_n && !hold_credits && pending.size() > 0 && pending[0] <= cycle) begin
				void'(pending.pop_front());
				uop_credit = 1'b1;
			end
		end
	end

	initial begin
		repeat (MAX_HALVES * 10 + 200) @(posedge clk);
		$display("Timeout: the decode stage stopped producing micro-ops, the run hangs");
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	// ##########################################################################
	// Stimulus
	// ##########################################################################

	initial begin
		void'($urandom(32'h8774579c));
		arst_n         = 1'b0;
		fetch_valid    = 1'b0;
		fetch_pkt      = '0;
		hold_credits   = 1'b0;
		fetch_credits  = `FETCH_BUF_DEPTH;
		pc             = 64'h8000_0000;
		cur_test       = "reset";
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		idle(2);

		cur_test = "directed";
		for (int i = 0; i < N_FORMS; i++) begin
			send_pkt(pc, {forms[(i + 1) % N_FORMS], forms[i]});
			pc += 64'd4;
		end
		wait_drain();

		cur_test = "misaligned";
		for (int i = 0; i < N_FORMS; i++) begin
			send_pkt(pc + 64'd2, {forms[i], 16'h0001});
			pc += 64'd4;
		end
		wait_drain();

		cur_test = "illegal";
		send_pkt(pc, {illegal_forms[1], illegal_forms[0]});
		send_pkt(pc + 64'd4, {illegal_forms[3], illegal_forms[2]});
		pc += 64'd8;
		wait_drain();

		cur_test     = "backpressure";
		hold_credits = 1'b1;
		mark         = uops_seen;
		for (int i = 0; i < 3; i++) begin
			send_pkt(pc, {random_half(), random_half()});
			pc += 64'd4;
		end
		idle(40);
		check_credit_count("backpressure window", `ISSUE_CREDITS, uops_seen - mark);
		hold_credits = 1'b0;
		wait_drain();

		cur_test = "random";
		for (int i = 0; i < N_RANDOM; i++) begin
			if ($urandom_range(0, 3) == 0)
				send_pkt(pc + 64'd2, {random_half(), 16'h0001});
			else
				send_pkt(pc, {random_half(), random_half()});
			pc += 64'd4;
			idle($urandom_range(0, 3));
		end

		// Every packet has left the buffer once fetch holds its full credit count again
		while (fetch_credits < `FETCH_BUF_DEPTH)
			idle(1);
		idle(2);  // The last micro-op is compared on the edge after the last pop
		check_credit_count("fetch credits", pkts_sent, credits_returned);
		if (exp_q.size() != 0)
			fail_now("Scoreboard still holds expected micro-ops at the end of the run");

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
rvc_pkg.sv
rvc_expander.sv
fetch_buffer.sv
issue_credit_counter.sv
half_select_fsm.sv
rvc_decode_top.sv
rvc_decode_properties.sv
rvc_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module rvc_decode_tb -o rvc_decode_sim

# The simulation exits nonzero on failure, the log search decides the result
./obj_dir/rvc_decode_sim > sim.log 2>&1 || true

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
